// ==== tb.f ====
+incdir+rtl
rtl/l2_data_pkg.sv
rtl/l2_data_way_ram.sv
rtl/l2_data_issue.sv
rtl/l2_data_access.sv
rtl/l2_data_respond.sv
rtl/l2_data_bank.sv
rtl/l2_cache_data.sv
testbench/l2_cache_data_tb.sv

// ==== testbench/l2_data_stimulus.txt ====
# test bank req we way set mshr wdata | expected: rvalid wvalid mshr rdata
# the expected columns give the bank's response 4 cycles after the line is driven
1 0 0 0 0 0 0 0 0 0 0 0
1 1 0 0 0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0 0 0 0 0
2 0 0 1 1 5 2 0123456789abcdeffedcba9876543210 0 1 2 0
2 0 0 0 0 0 0 0 0 0 0 0
2 0 1 0 1 5 3 0 1 0 3 0123456789abcdeffedcba9876543210
3 1 0 1 0 9 0 11111111222222223333333344444444 0 1 0 0
3 1 0 1 1 9 1 55555555666666667777777788888888 0 1 1 0
3 1 0 1 2 9 2 99999999aaaaaaaabbbbbbbbcccccccc 0 1 2 0
3 1 0 1 3 9 3 ddddddddeeeeeeeeffffffff00000000 0 1 3 0
3 0 0 1 2 9 1 13579bdf02468ace13579bdf02468ace 0 1 1 0
3 1 1 0 3 9 0 0 1 0 0 ddddddddeeeeeeeeffffffff00000000
3 1 1 0 0 9 1 0 1 0 1 11111111222222223333333344444444
3 0 1 0 2 9 2 0 1 0 2 13579bdf02468ace13579bdf02468ace
3 1 1 0 2 9 3 0 1 0 3 99999999aaaaaaaabbbbbbbbcccccccc
4 1 1 0 1 9 0 0 1 0 0 55555555666666667777777788888888
4 1 1 0 0 9 1 0 1 0 1 11111111222222223333333344444444
4 1 1 0 3 9 2 0 1 0 2 ddddddddeeeeeeeeffffffff00000000
5 0 1 1 3 0 1 a5a5a5a55a5a5a5af0f0f0f00f0f0f0f 0 1 1 0
5 0 1 0 3 0 0 0 1 0 0 a5a5a5a55a5a5a5af0f0f0f00f0f0f0f
5 0 0 0 0 0 0 0 0 0 0 0

// ==== testbench/l2_cache_data_tb.sv ====
`include "l2_data_cfg.svh"

module l2_cache_data_tb
    import l2_data_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic [7:0] test;
        logic [7:0] bank;
        logic       req;
        logic       we;
        way_t       way;
        bank_set_t  set;
        mshr_idx_t  mshr;
        line_t      wdata;
        bank_rsp_t  exp;
    } op_t;

    typedef struct packed {
        int unsigned                        due;  // cycle in which the response shows
        logic [7:0]                         test;
        bank_rsp_t [`L2_DATA_BANKS-1:0]     rsp;
    } exp_t;

    logic                      clk;
    logic                      rst;
    logic [`L2_DATA_BANKS-1:0] req;
    rd_req_t                   rd_req [`L2_DATA_BANKS];
    logic [`L2_DATA_BANKS-1:0] ready;
    logic [`L2_DATA_BANKS-1:0] we;
    wr_req_t                   wr_req [`L2_DATA_BANKS];
    bank_rsp_t                 rsp    [`L2_DATA_BANKS];

    op_t                       ops [$];
    exp_t                      exp_q [$];
    logic [`L2_DATA_BANKS-1:0] exp_ready;
    bit                        loaded;
    int unsigned               cyc;
    int                        cur_test;
    int                        test_errs;
    int                        tests_run;
    int                        tests_failed;
    int                        checks;
    int                        errors;

    l2_cache_data i_dut (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rd_req (rd_req),
        .ready  (ready),
        .we     (we),
        .wr_req (wr_req),
        .rsp    (rsp)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            test_errs++;
            $display("Mismatch %s: got %0h, expected %0h", name, got, exp);
        end
    endtask

    task automatic load_ops();
        int    fd;
        int    n;
        string text;
        int    tn, bk, rq, w, wy, st, ms, erv, ewv, ems;
        logic [127:0] wd, erd;
        op_t   op;
        fd = $fopen("testbench/l2_data_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file testbench/l2_data_stimulus.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            text = "";
            void'($fgets(text, fd));
            if (text.len() == 0 || text.getc(0) == "#") continue;  // column notes
            n = $sscanf(text, "%d %d %d %d %d %d %d %h %d %d %d %h",
                        tn, bk, rq, w, wy, st, ms, wd, erv, ewv, ems, erd);
            if (n <= 0) continue;
            if (n != 12 || bk >= `L2_DATA_BANKS) begin
                $display("stimulus line is malformed or names a missing bank: %s", text);
                errors++;
                continue;
            end
            op.test         = tn;
            op.bank         = bk;
            op.req          = rq[0];
            op.we           = w[0];
            op.way          = wy;
            op.set          = st;
            op.mshr         = ms;
            op.wdata        = wd;
            op.exp.rvalid   = erv[0];
            op.exp.wvalid   = ewv[0];
            op.exp.mshr_idx = ems;
            op.exp.rdata    = erd;
            ops.push_back(op);
        end
        $fclose(fd);
    endtask

    function automatic wr_req_t random_wr();
        logic [159:0] r;
        r = {$urandom, $urandom, $urandom, $urandom, $urandom};
        return wr_req_t'(r[$bits(wr_req_t)-1:0]);
    endfunction

    task automatic finish_test();
        if (cur_test != 0) begin
            tests_run++;
            if (test_errs != 0) tests_failed++;
            $display("test %0d finished, %0d errors", cur_test, test_errs);
            test_errs = 0;
        end
    endtask

    // idle strobes with random don't-care fields on every bank
    task automatic drive_idle();
        for (int b = 0; b < `L2_DATA_BANKS; b++) begin
            req[b]    = 1'b0;
            we[b]     = 1'b0;
            rd_req[b] = rd_req_t'($urandom);
            wr_req[b] = random_wr();
        end
        exp_ready = '1;
    endtask

    task automatic drive_op(input op_t op);
        exp_t e;
        drive_idle();
        req[op.bank] = op.req;
        we[op.bank]  = op.we;
        if (op.we) begin
            wr_req[op.bank] = '{way: op.way, set: op.set, mshr_idx: op.mshr, data: op.wdata};
        end else if (op.req) begin
            rd_req[op.bank] = '{way: op.way, set: op.set, mshr_idx: op.mshr};
        end
        exp_ready[op.bank] = ~op.we;  // write owns the port
        e     = '0;
        e.due = cyc + `L2_DATA_LATENCY;
        e.test = op.test;
        e.rsp[op.bank] = op.exp;
        exp_q.push_back(e);
    endtask

    // samples outputs mid-cycle before the next drive
    task automatic check_cycle();
        exp_t e;
        e = '0;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            if (e.test != cur_test) begin
                finish_test();
                cur_test = e.test;
            end
        end
        check("ready", ready, exp_ready);
        for (int b = 0; b < `L2_DATA_BANKS; b++) begin
            check($sformatf("rsp[%0d].rvalid", b), rsp[b].rvalid, e.rsp[b].rvalid);
            check($sformatf("rsp[%0d].wvalid", b), rsp[b].wvalid, e.rsp[b].wvalid);
            if (e.rsp[b].rvalid || e.rsp[b].wvalid)
                check($sformatf("rsp[%0d].mshr_idx", b), rsp[b].mshr_idx, e.rsp[b].mshr_idx);
            if (e.rsp[b].rvalid)
                check($sformatf("rsp[%0d].rdata", b), rsp[b].rdata, e.rsp[b].rdata);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(32'h5617));
        rst = 1'b1;
        drive_idle();
        load_ops();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < ops.size(); i++) begin
            check_cycle();
            drive_op(ops[i]);
            cyc++;
            @(negedge clk);
        end
        while (exp_q.size() > 0) begin  // drain the pipeline
            check_cycle();
            drive_idle();
            cyc++;
            @(negedge clk);
        end
        finish_test();
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        #((ops.size() + 10) * 40);
        $display("watchdog expired before all responses were checked");
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== rtl/l2_cache_data.sv ====
`include "l2_data_cfg.svh"

module l2_cache_data
    import l2_data_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`L2_DATA_BANKS-1:0] req,
    input  rd_req_t                   rd_req [`L2_DATA_BANKS],
    output logic [`L2_DATA_BANKS-1:0] ready,
    input  logic [`L2_DATA_BANKS-1:0] we,
    input  wr_req_t                   wr_req [`L2_DATA_BANKS],
    output bank_rsp_t                 rsp    [`L2_DATA_BANKS]
);

    // ------------------------------------------------------------------------
    // independent banks with one read and one write port each
    // ------------------------------------------------------------------------
    for (genvar b = 0; b < `L2_DATA_BANKS; b++) begin : g_bank
        l2_data_bank i_bank (
            .clk    (clk),
            .rst    (rst),
            .req    (req[b]),
            .rd_req (rd_req[b]),
            .ready  (ready[b]),
            .we     (we[b]),
            .wr_req (wr_req[b]),
            .rsp    (rsp[b])
        );
    end

endmodule

// ==== rtl/l2_data_bank.sv ====
module l2_data_bank
    import l2_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  rd_req_t   rd_req,
    output logic      ready,
    input  logic      we,
    input  wr_req_t   wr_req,
    output bank_rsp_t rsp
);

    bank_cmd_t issue_cmd;   // issue -> access
    bank_cmd_t access_cmd;  // access -> respond
    line_t     access_line;

    l2_data_issue i_issue (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .rd_req (rd_req),
        .we     (we),
        .wr_req (wr_req),
        .ready  (ready),
        .cmd    (issue_cmd)
    );

    l2_data_access i_access (
        .clk   (clk),
        .rst   (rst),
        .cmd   (issue_cmd),
        .cmd_q (access_cmd),
        .line  (access_line)
    );

    l2_data_respond i_respond (
        .clk  (clk),
        .rst  (rst),
        .cmd  (access_cmd),
        .line (access_line),
        .rsp  (rsp)
    );

endmodule

// ==== rtl/l2_data_respond.sv ====
`include "l2_data_cfg.svh"

module l2_data_respond
    import l2_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  bank_cmd_t cmd,
    input  line_t     line,
    output bank_rsp_t rsp
);

    bank_cmd_t cmd_pipe  [0:`L2_APPEND_PIPE];
    line_t     line_pipe [0:`L2_APPEND_PIPE];

    assign cmd_pipe[0]  = cmd;
    assign line_pipe[0] = line;

    // ------------------------------------------------------------------------
    // append delay
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `L2_APPEND_PIPE; i++) begin : g_append
        always_ff @(posedge clk) begin
            cmd_pipe[i+1]  <= cmd_pipe[i];
            line_pipe[i+1] <= line_pipe[i];
            if (rst) begin
                cmd_pipe[i+1].rd <= 1'b0;
                cmd_pipe[i+1].wr <= 1'b0;
            end
        end
    end

    // rd and wr never both set, so one index serves both strobes
    always_comb begin
        rsp.rvalid   = cmd_pipe[`L2_APPEND_PIPE].rd;
        rsp.wvalid   = cmd_pipe[`L2_APPEND_PIPE].wr;
        rsp.mshr_idx = cmd_pipe[`L2_APPEND_PIPE].mshr_idx;
        rsp.rdata    = line_pipe[`L2_APPEND_PIPE];
    end

endmodule

// ==== rtl/l2_data_access.sv ====
`include "l2_data_cfg.svh"

module l2_data_access
    import l2_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  bank_cmd_t cmd,
    output bank_cmd_t cmd_q,
    output line_t     line
);

    logic [`L2_WAYS-1:0] way_sel;
    line_t               way_rdata [`L2_WAYS];

    // one-hot way decode
    always_comb begin
        way_sel = '0;
        way_sel[cmd.way] = 1'b1;
    end

    // ------------------------------------------------------------------------
    // way memories with only the addressed one enabled
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `L2_WAYS; i++) begin : g_way
        l2_data_way_ram i_way_ram (
            .clk   (clk),
            .en    ((cmd.rd | cmd.wr) & way_sel[i]),
            .wr    (cmd.wr),
            .set   (cmd.set),
            .wdata (cmd.data),
            .rdata (way_rdata[i])
        );
    end

    // command follows the read data by the same one cycle
    always_ff @(posedge clk) begin
        cmd_q <= cmd;
        if (rst) begin
            cmd_q.rd <= 1'b0;
            cmd_q.wr <= 1'b0;
        end
    end

    assign line = way_rdata[cmd_q.way];  // stale on writes and masked by rvalid

endmodule

// ==== rtl/l2_data_issue.sv ====
`include "l2_data_cfg.svh"

module l2_data_issue
    import l2_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      req,
    input  rd_req_t   rd_req,
    input  logic      we,
    input  wr_req_t   wr_req,
    output logic      ready,
    output bank_cmd_t cmd
);

    bank_cmd_t merged;
    bank_cmd_t stage [0:`L2_PREPEND_PIPE];  // [0] is the issue register

    assign ready = ~we;  // the write owns the port this cycle

    // ------------------------------------------------------------------------
    // port merge with write priority
    // ------------------------------------------------------------------------
    always_comb begin
        merged.data = wr_req.data;
        if (we) begin
            merged.rd       = 1'b0;
            merged.wr       = 1'b1;
            merged.way      = wr_req.way;
            merged.set      = wr_req.set;
            merged.mshr_idx = wr_req.mshr_idx;
        end else begin
            merged.rd       = req;
            merged.wr       = 1'b0;
            merged.way      = rd_req.way;
            merged.set      = rd_req.set;
            merged.mshr_idx = rd_req.mshr_idx;
        end
    end

    always_ff @(posedge clk) begin
        stage[0] <= merged;
        if (rst) begin
            stage[0].rd <= 1'b0;
            stage[0].wr <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // prepend delay
    // ------------------------------------------------------------------------
    for (genvar i = 0; i < `L2_PREPEND_PIPE; i++) begin : g_prepend
        always_ff @(posedge clk) begin
            stage[i+1] <= stage[i];
            if (rst) begin
                stage[i+1].rd <= 1'b0;
                stage[i+1].wr <= 1'b0;
            end
        end
    end

    assign cmd = stage[`L2_PREPEND_PIPE];

endmodule

// ==== rtl/l2_data_way_ram.sv ====
module l2_data_way_ram
    import l2_data_pkg::*;
(
    input  logic      clk,
    input  logic      en,
    input  logic      wr,
    input  bank_set_t set,
    input  line_t     wdata,
    output line_t     rdata
);

    localparam int DEPTH = 2 ** $bits(bank_set_t);  // sets held by one bank

    line_t mem [DEPTH];

    // a write leaves the read register untouched
    always_ff @(posedge clk) begin
        if (en) begin
            if (wr) begin
                mem[set] <= wdata;
            end else begin
                rdata <= mem[set];
            end
        end
    end

endmodule

// ==== rtl/l2_data_pkg.sv ====
`include "l2_data_cfg.svh"

package l2_data_pkg;

    typedef logic [$clog2(`L2_WAYS)-1:0]                  way_t;
    typedef logic [$clog2(`L2_SETS / `L2_DATA_BANKS)-1:0] bank_set_t;  // set within a bank
    typedef logic [$clog2(`L2_MSHR_SIZE)-1:0]             mshr_idx_t;
    typedef logic [`L2_WORD_BITS-1:0]                     word_t;
    typedef word_t [`L2_WORDS-1:0]                        line_t;

    typedef struct packed {
        way_t      way;
        bank_set_t set;
        mshr_idx_t mshr_idx;
    } rd_req_t;

    typedef struct packed {
        way_t      way;
        bank_set_t set;
        mshr_idx_t mshr_idx;
        line_t     data;
    } wr_req_t;

    // one slot of the bank pipeline
    typedef struct packed {
        logic      rd;
        logic      wr;
        way_t      way;
        bank_set_t set;
        mshr_idx_t mshr_idx;
        line_t     data;
    } bank_cmd_t;

    typedef struct packed {
        logic      rvalid;
        logic      wvalid;
        mshr_idx_t mshr_idx;
        line_t     rdata;           // only meaningful with rvalid
    } bank_rsp_t;

endpackage

// ==== rtl/l2_data_cfg.svh ====
`ifndef L2_DATA_CFG_SVH
`define L2_DATA_CFG_SVH

// ------------------------------------------------------------------------
// line and word geometry
// ------------------------------------------------------------------------
`define L2_LINE_BYTES   16
`define L2_WORDS        4
`define L2_WORD_BITS    (`L2_LINE_BYTES * 8 / `L2_WORDS)

// ------------------------------------------------------------------------
// array organisation
// ------------------------------------------------------------------------
`define L2_WAYS         4
`define L2_SETS         32      // whole array split across the banks
`define L2_DATA_BANKS   2
`define L2_MSHR_SIZE    4

// ------------------------------------------------------------------------
// pipeline depth
// ------------------------------------------------------------------------
`define L2_PREPEND_PIPE 1
`define L2_APPEND_PIPE  1
`define L2_DATA_LATENCY (`L2_PREPEND_PIPE + `L2_APPEND_PIPE + 2)

`endif
